//--- logic/data_ram_1r1w.sv
//**************************************************
// data RAM, one read and one write port
// read data is registered, one cycle latency
// same-cycle read and write of a word gives old data
// contents are undefined after reset
//**************************************************
`timescale 1ns/1ns
`include "lsu_params.svh"

module data_ram_1r1w (
	input  logic                   clk,
	input  logic [`LSU_RAM_AW-1:0] ram_radr,
	output logic [31:0]            ram_rdata,
	input  logic [`LSU_RAM_AW-1:0] ram_wadr,
	input  logic [31:0]            ram_wdata,
	input  logic [3:0]             ram_wen
);

	localparam int DEPTH = 1 << `LSU_RAM_AW;

	logic [31:0] mem [DEPTH];

	// registered read
	always_ff @(posedge clk) begin
		ram_rdata <= mem[ram_radr];
	end

	// per-lane write
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (ram_wen[i]) begin
				mem[ram_wadr][i*8 +: 8] <= ram_wdata[i*8 +: 8];
			end
		end
	end

endmodule

//--- logic/io_regs.sv
//**************************************************
// IO register block
// 16-bit registers, selected by the low word-address
// bits; upper address bits are ignored so the block
// repeats through the IO region
// writes are whole registers, reads take one cycle
//**************************************************
`timescale 1ns/1ns
`include "lsu_params.svh"

module io_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   io_we,
	input  logic [`LSU_DMA_AW-1:0] io_wadr,
	input  logic [15:0]            io_wdata,
	input  logic [`LSU_DMA_AW-1:0] io_radr,
	output logic [15:0]            io_rdata
);

	localparam int IDX_W = $clog2(`LSU_IO_REGS);

	logic [15:0]      regs [`LSU_IO_REGS];
	logic [IDX_W-1:0] widx;
	logic [IDX_W-1:0] ridx;

	// addr[5:2] for 16 registers
	assign widx = io_wadr[IDX_W-1:0];
	assign ridx = io_radr[IDX_W-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `LSU_IO_REGS; i++) begin
				regs[i] <= 16'd0;
			end
		end else if (io_we) begin
			regs[widx] <= io_wdata;
		end
	end

	// read sees the value before a same-cycle write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			io_rdata <= 16'd0;
		end else begin
			io_rdata <= regs[ridx];
		end
	end

endmodule

//--- logic/lsu_params.svh
//**************************************************
// sizes of the memory-access slice
// RAM is word addressed, byte offset is not part of it
// DMA addresses are word addresses (byte bits 15:2);
// only the low LSU_RAM_AW bits reach the RAM
// IO_REGS must be a power of two
//**************************************************
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// 4096 words of 32 bits
`define LSU_RAM_AW 12

// addr[31:30] value that maps to the IO block
`define LSU_IO_SEL 2'b11

`define LSU_IO_REGS 16

`define LSU_DMA_AW 14

`endif

//--- logic/lsu_pkg.sv
//**************************************************
// shared types of the load/store path
// ldst_code_e follows RV32I funct3, stores use
// only B, H and W
//**************************************************
package lsu_pkg;

	// funct3 of RV32I loads and stores
	typedef enum logic [2:0] {
		LDST_B  = 3'b000,
		LDST_H  = 3'b001,
		LDST_W  = 3'b010,
		LDST_BU = 3'b100,
		LDST_HU = 3'b101
	} ldst_code_e;

	// target of an access, from addr[31:30]
	typedef enum logic {
		REGION_RAM = 1'b0,
		REGION_IO  = 1'b1
	} mem_region_e;

endpackage

//--- logic/ma_stage.sv
//**************************************************
// memory-access stage
// one load or store per cycle, sampled when stall
// is low; stores write on their sampling edge
// DMA overrides the CPU port, never in the same
// cycle as a CPU access of the same kind
// rst_pipe wins over stall
//**************************************************
`timescale 1ns/1ns
`include "lsu_params.svh"

module ma_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall,
	input  logic                   rst_pipe,
	input  logic                   cmd_ld,
	input  logic                   cmd_st,
	input  lsu_pkg::ldst_code_e    ldst_code,
	input  logic [31:0]            addr,
	input  logic [31:0]            st_data,
	input  logic [4:0]             rd_adr,
	input  logic                   wbk_rd_reg,
	input  logic                   dma_we,
	input  logic [`LSU_DMA_AW-1:0] dma_wadr,
	input  logic [15:0]            dma_wdata,
	input  logic                   dma_re,
	input  logic [`LSU_DMA_AW-1:0] dma_radr,
	output logic [15:0]            dma_rdata,
	output logic [`LSU_RAM_AW-1:0] ram_radr,
	input  logic [31:0]            ram_rdata,
	output logic [`LSU_RAM_AW-1:0] ram_wadr,
	output logic [31:0]            ram_wdata,
	output logic [3:0]             ram_wen,
	output logic                   io_we,
	output logic [`LSU_DMA_AW-1:0] io_wadr,
	output logic [15:0]            io_wdata,
	output logic [`LSU_DMA_AW-1:0] io_radr,
	input  logic [15:0]            io_rdata,
	output logic                   ld_cmd_wb,
	output logic                   wbk_rd_reg_wb,
	output lsu_pkg::ldst_code_e    ld_code_wb,
	output logic [1:0]             ld_ofs_wb,
	output logic [4:0]             rd_adr_wb,
	output logic [31:0]            alu_data_wb,
	output logic [31:0]            ld_data_wb
);

	import lsu_pkg::*;

	mem_region_e region;
	logic [31:0] lane_data;
	logic [3:0]  lane_be;
	logic        io_rd_sel;
	logic        io_rd_wb;
	logic        dma_rd_wb;
	logic [31:0] rd_data_mux;
	logic        stall_dly;
	logic        stall_1shot;
	logic [31:0] ld_data_roll;

	assign region = (addr[31:30] == `LSU_IO_SEL) ? REGION_IO : REGION_RAM;

	// a held store under stall is not repeated
	store_align u_store_align (
		.ldst_code(ldst_code),
		.ofs      (addr[1:0]),
		.cmd_st   (cmd_st & ~stall),
		.st_data  (st_data),
		.lane_data(lane_data),
		.lane_be  (lane_be)
	);

	// RAM ports, DMA first
	assign ram_radr  = dma_re ? dma_radr[`LSU_RAM_AW-1:0] : addr[`LSU_RAM_AW+1:2];
	assign ram_wadr  = dma_we ? dma_wadr[`LSU_RAM_AW-1:0] : addr[`LSU_RAM_AW+1:2];
	assign ram_wdata = dma_we ? {16'd0, dma_wdata} : lane_data;
	assign ram_wen   = dma_we ? 4'b1111 : (lane_be & {4{region == REGION_RAM}});

	// IO needs both low lanes, so SB to IO is dropped
	assign io_we    = lane_be[1] & lane_be[0] & (region == REGION_IO);
	assign io_wadr  = addr[`LSU_DMA_AW+1:2];
	assign io_wdata = lane_data[15:0];
	assign io_radr  = addr[`LSU_DMA_AW+1:2];

	assign io_rd_sel = cmd_ld & (region == REGION_IO) & ~dma_re;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			io_rd_wb <= 1'b0;
			dma_rd_wb <= 1'b0;
			stall_dly <= 1'b0;
		end else begin
			io_rd_wb <= io_rd_sel;
			dma_rd_wb <= dma_re;
			stall_dly <= stall;
		end
	end

	assign rd_data_mux = io_rd_wb ? {16'd0, io_rdata} : ram_rdata;
	assign dma_rdata   = dma_rd_wb ? ram_rdata[15:0] : 16'd0;

	// read data of the stalled load, caught on the first stall edge
	assign stall_1shot = stall & ~stall_dly;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ld_data_roll <= 32'd0;
		end else if (rst_pipe) begin
			ld_data_roll <= 32'd0;
		end else if (stall_1shot) begin
			ld_data_roll <= rd_data_mux;
		end
	end

	assign ld_data_wb = stall_dly ? ld_data_roll : rd_data_mux;

	// write-back registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ld_cmd_wb <= 1'b0;
			wbk_rd_reg_wb <= 1'b0;
			ld_code_wb <= LDST_B;
			ld_ofs_wb <= 2'd0;
			rd_adr_wb <= 5'd0;
			alu_data_wb <= 32'd0;
		end else if (rst_pipe) begin
			ld_cmd_wb <= 1'b0;
			wbk_rd_reg_wb <= 1'b0;
			ld_code_wb <= LDST_B;
			ld_ofs_wb <= 2'd0;
			rd_adr_wb <= 5'd0;
			alu_data_wb <= 32'd0;
		end else if (!stall) begin
			ld_cmd_wb <= cmd_ld;
			wbk_rd_reg_wb <= wbk_rd_reg;
			ld_code_wb <= ldst_code;
			ld_ofs_wb <= addr[1:0];
			rd_adr_wb <= rd_adr;
			alu_data_wb <= addr;
		end
	end

	// DMA shares the RAM ports with the CPU
	a_dma_rd_conflict: assert property (@(posedge clk) disable iff (!rst_n)
		!(dma_re && cmd_ld))
		else $error("dma_re in the same cycle as a CPU load");

	a_dma_wr_conflict: assert property (@(posedge clk) disable iff (!rst_n)
		!(dma_we && cmd_st))
		else $error("dma_we in the same cycle as a CPU store");

endmodule

//--- logic/mem_access_top.sv
//**************************************************
// memory-access and write-back slice
// execute-side inputs are held by the driver while
// stall is high
// wb outputs follow the write-back registers
//**************************************************
`timescale 1ns/1ns
`include "lsu_params.svh"

module mem_access_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   stall,
	input  logic                   rst_pipe,
	input  logic                   cmd_ld,
	input  logic                   cmd_st,
	input  lsu_pkg::ldst_code_e    ldst_code,
	input  logic [31:0]            addr,
	input  logic [31:0]            st_data,
	input  logic [4:0]             rd_adr,
	input  logic                   wbk_rd_reg,
	input  logic                   dma_we,
	input  logic [`LSU_DMA_AW-1:0] dma_wadr,
	input  logic [15:0]            dma_wdata,
	input  logic                   dma_re,
	input  logic [`LSU_DMA_AW-1:0] dma_radr,
	output logic [15:0]            dma_rdata,
	output logic                   wb_we,
	output logic [4:0]             wb_rd_adr,
	output logic [31:0]            wb_data
);

	import lsu_pkg::*;

	logic [`LSU_RAM_AW-1:0] ram_radr;
	logic [31:0]            ram_rdata;
	logic [`LSU_RAM_AW-1:0] ram_wadr;
	logic [31:0]            ram_wdata;
	logic [3:0]             ram_wen;
	logic                   io_we;
	logic [`LSU_DMA_AW-1:0] io_wadr;
	logic [15:0]            io_wdata;
	logic [`LSU_DMA_AW-1:0] io_radr;
	logic [15:0]            io_rdata;
	logic                   ld_cmd_wb;
	logic                   wbk_rd_reg_wb;
	ldst_code_e             ld_code_wb;
	logic [1:0]             ld_ofs_wb;
	logic [4:0]             rd_adr_wb;
	logic [31:0]            alu_data_wb;
	logic [31:0]            ld_data_wb;

	ma_stage u_ma_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.stall        (stall),
		.rst_pipe     (rst_pipe),
		.cmd_ld       (cmd_ld),
		.cmd_st       (cmd_st),
		.ldst_code    (ldst_code),
		.addr         (addr),
		.st_data      (st_data),
		.rd_adr       (rd_adr),
		.wbk_rd_reg   (wbk_rd_reg),
		.dma_we       (dma_we),
		.dma_wadr     (dma_wadr),
		.dma_wdata    (dma_wdata),
		.dma_re       (dma_re),
		.dma_radr     (dma_radr),
		.dma_rdata    (dma_rdata),
		.ram_radr     (ram_radr),
		.ram_rdata    (ram_rdata),
		.ram_wadr     (ram_wadr),
		.ram_wdata    (ram_wdata),
		.ram_wen      (ram_wen),
		.io_we        (io_we),
		.io_wadr      (io_wadr),
		.io_wdata     (io_wdata),
		.io_radr      (io_radr),
		.io_rdata     (io_rdata),
		.ld_cmd_wb    (ld_cmd_wb),
		.wbk_rd_reg_wb(wbk_rd_reg_wb),
		.ld_code_wb   (ld_code_wb),
		.ld_ofs_wb    (ld_ofs_wb),
		.rd_adr_wb    (rd_adr_wb),
		.alu_data_wb  (alu_data_wb),
		.ld_data_wb   (ld_data_wb)
	);

	data_ram_1r1w u_data_ram (
		.clk      (clk),
		.ram_radr (ram_radr),
		.ram_rdata(ram_rdata),
		.ram_wadr (ram_wadr),
		.ram_wdata(ram_wdata),
		.ram_wen  (ram_wen)
	);

	io_regs u_io_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.io_we   (io_we),
		.io_wadr (io_wadr),
		.io_wdata(io_wdata),
		.io_radr (io_radr),
		.io_rdata(io_rdata)
	);

	wb_load_ext u_wb_load_ext (
		.ld_cmd_wb    (ld_cmd_wb),
		.wbk_rd_reg_wb(wbk_rd_reg_wb),
		.ld_code_wb   (ld_code_wb),
		.ld_ofs_wb    (ld_ofs_wb),
		.rd_adr_wb    (rd_adr_wb),
		.alu_data_wb  (alu_data_wb),
		.ld_data_wb   (ld_data_wb),
		.wb_we        (wb_we),
		.wb_rd_adr    (wb_rd_adr),
		.wb_data      (wb_data)
	);

endmodule

//--- logic/store_align.sv
//**************************************************
// store lane alignment
// no misalignment check, the offset is used as is
// a halfword goes to lanes 1:0 or 3:2 by ofs[1]
// enables are zero unless cmd_st is set
//**************************************************
`timescale 1ns/1ns

module store_align (
	input  lsu_pkg::ldst_code_e ldst_code,
	input  logic [1:0]          ofs,
	input  logic                cmd_st,
	input  logic [31:0]         st_data,
	output logic [31:0]         lane_data,
	output logic [3:0]          lane_be
);

	import lsu_pkg::*;

	logic [3:0] be_raw;

	always_comb begin
		lane_data = 32'd0;
		be_raw = 4'd0;
		case (ldst_code)
			LDST_B: begin
				// byte moves to lane ofs
				lane_data = {24'd0, st_data[7:0]} << {ofs, 3'b000};
				be_raw = 4'b0001 << ofs;
			end
			LDST_H: begin
				if (ofs[1]) begin
					lane_data = {st_data[15:0], 16'd0};
					be_raw = 4'b1100;
				end else begin
					lane_data = {16'd0, st_data[15:0]};
					be_raw = 4'b0011;
				end
			end
			LDST_W: begin
				lane_data = st_data;
				be_raw = 4'b1111;
			end
			default: begin
				lane_data = 32'd0;
				be_raw = 4'd0;
			end
		endcase
	end

	assign lane_be = be_raw & {4{cmd_st}};

	// unsigned codes have no store form
	always_comb begin
		if (cmd_st) begin
			assert #0 (ldst_code inside {LDST_B, LDST_H, LDST_W})
				else $error("store with load-only code %0d", ldst_code);
		end
	end

endmodule

//--- logic/wb_load_ext.sv
//**************************************************
// write-back value and enable
// loads pick the addressed byte or halfword and
// extend it, anything else writes alu_data_wb
// writes to x0 are suppressed
//**************************************************
`timescale 1ns/1ns

module wb_load_ext (
	input  logic                ld_cmd_wb,
	input  logic                wbk_rd_reg_wb,
	input  lsu_pkg::ldst_code_e ld_code_wb,
	input  logic [1:0]          ld_ofs_wb,
	input  logic [4:0]          rd_adr_wb,
	input  logic [31:0]         alu_data_wb,
	input  logic [31:0]         ld_data_wb,
	output logic                wb_we,
	output logic [4:0]          wb_rd_adr,
	output logic [31:0]         wb_data
);

	import lsu_pkg::*;

	logic [31:0] byte_shift;
	logic [7:0]  ld_byte;
	logic [15:0] ld_half;
	logic [31:0] ld_val;

	assign byte_shift = ld_data_wb >> {ld_ofs_wb, 3'b000};
	assign ld_byte = byte_shift[7:0];
	// halfword lanes by bit 1 only
	assign ld_half = ld_ofs_wb[1] ? ld_data_wb[31:16] : ld_data_wb[15:0];

	always_comb begin
		case (ld_code_wb)
			LDST_B:  ld_val = {{24{ld_byte[7]}}, ld_byte};
			LDST_BU: ld_val = {24'd0, ld_byte};
			LDST_H:  ld_val = {{16{ld_half[15]}}, ld_half};
			LDST_HU: ld_val = {16'd0, ld_half};
			LDST_W:  ld_val = ld_data_wb;
			default: ld_val = ld_data_wb;
		endcase
	end

	assign wb_data   = ld_cmd_wb ? ld_val : alu_data_wb;
	assign wb_we     = wbk_rd_reg_wb & (rd_adr_wb != 5'd0);
	assign wb_rd_adr = rd_adr_wb;

endmodule

//--- mem_access_top.f
+incdir+logic
logic/lsu_pkg.sv
logic/store_align.sv
logic/data_ram_1r1w.sv
logic/io_regs.sv
logic/ma_stage.sv
logic/wb_load_ext.sv
logic/mem_access_top.sv
tb/tb_mem_access.sv

//--- tb/tb_mem_access.sv
//**************************************************
// testbench for the memory-access slice
// RAM model words are unknown until written, so
// loads only read words stored earlier in the run
// wb outputs are checked at every falling edge
//**************************************************
`timescale 1ns/1ns
`include "lsu_params.svh"

module tb_mem_access;

	import lsu_pkg::*;

	logic clk, rst_n, stall, rst_pipe, cmd_ld, cmd_st, wbk_rd_reg;
	ldst_code_e ldst_code;
	logic [31:0] addr, st_data;
	logic [4:0] rd_adr;
	logic dma_we, dma_re;
	logic [`LSU_DMA_AW-1:0] dma_wadr, dma_radr;
	logic [15:0] dma_wdata, dma_rdata;
	logic wb_we;
	logic [4:0] wb_rd_adr;
	logic [31:0] wb_data;

	logic [31:0] ram_model [1 << `LSU_RAM_AW];
	logic [15:0] io_model [`LSU_IO_REGS];
	logic [31:0] lfsr = 32'h988a;
	int errors = 0;

	// expected write-back, driven with the command, then taken in like the wb registers
	logic pend_we = 1'b0, cur_we = 1'b0;
	logic [4:0] pend_rd = 5'd0, cur_rd = 5'd0;
	logic [31:0] pend_data = 32'd0, cur_data = 32'd0;
	string pend_name = "reset", cur_name = "reset";

	mem_access_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic b;
		r = 32'd0;
		for (int i = 0; i < n; i++) begin
			b = lfsr[0];
			lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'd0);
			r = {r[30:0], b};
		end
		return r;
	endfunction

	function automatic logic [31:0] model_word(input logic [31:0] a);
		if (a[31:30] == 2'b11)
			return {16'd0, io_model[a[5:2]]};
		return ram_model[a[13:2]];
	endfunction

	// expected register value of a load
	function automatic logic [31:0] ext_ref(input ldst_code_e code, input logic [1:0] ofs,
			input logic [31:0] w);
		logic [7:0] b;
		logic [15:0] h;
		b = w[ofs*8 +: 8];
		h = w[ofs[1]*16 +: 16];
		case (code)
			LDST_B:  return {{24{b[7]}}, b};
			LDST_BU: return {24'd0, b};
			LDST_H:  return {{16{h[15]}}, h};
			LDST_HU: return {16'd0, h};
			default: return w;
		endcase
	endfunction

	task automatic apply_store(input ldst_code_e code, input logic [31:0] a,
			input logic [31:0] d);
		logic [31:0] w;
		w = ram_model[a[13:2]];
		// IO only takes halfword or word data on lanes 1:0
		if (a[31:30] == 2'b11) begin
			if (code == LDST_W || (code == LDST_H && !a[1]))
				io_model[a[5:2]] = d[15:0];
		end else begin
			case (code)
				LDST_B: w[a[1:0]*8 +: 8] = d[7:0];
				LDST_H: w[a[1]*16 +: 16] = d[15:0];
				default: w = d;
			endcase
			ram_model[a[13:2]] = w;
		end
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			errors++;
			$display("ERR %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic issue(input logic ld, input logic st, input ldst_code_e code,
			input logic [31:0] a, input logic [31:0] d, input logic [4:0] rd,
			input logic wbk, input string name);
		logic [31:0] exp;
		exp = ld ? ext_ref(code, a[1:0], model_word(a)) : a;
		if (st)
			apply_store(code, a, d);
		@(posedge clk);
		cmd_ld <= ld;
		cmd_st <= st;
		ldst_code <= code;
		addr <= a;
		st_data <= d;
		rd_adr <= rd;
		wbk_rd_reg <= wbk;
		pend_we <= wbk && (rd != 5'd0);
		pend_rd <= rd;
		pend_data <= exp;
		pend_name <= name;
	endtask

	task automatic dma_read_check(input logic [`LSU_DMA_AW-1:0] ra, input logic [15:0] exp);
		logic got;
		int waited;
		got = 1'b0;
		waited = 0;
		@(posedge clk);
		dma_re <= 1'b1;
		dma_radr <= ra;
		@(posedge clk);
		dma_re <= 1'b0;
		for (int t = 0; t < 4 && !got; t++) begin
			@(negedge clk);
			got = (dma_rdata != 16'd0);
			waited++;
		end
		if (!got) begin
			errors++;
			$display("DMA read data did not arrive within 4 cycles");
		end else begin
			if (waited != 1) begin
				errors++;
				$display("DMA read data arrived %0d cycles after dma_re instead of 1", waited);
			end
			check("dma_read", {16'd0, exp}, {16'd0, dma_rdata});
		end
	endtask

	// compare process
	always @(posedge clk) begin
		if (!rst_n || rst_pipe) begin
			cur_we <= 1'b0;
			cur_rd <= 5'd0;
			cur_data <= 32'd0;
			cur_name <= rst_n ? "rst_pipe" : "reset";
		end else if (!stall) begin
			cur_we <= pend_we;
			cur_rd <= pend_rd;
			cur_data <= pend_data;
			cur_name <= pend_name;
		end
	end

	always @(negedge clk) begin
		if (rst_n) begin
			check({cur_name, ".we"}, {31'd0, cur_we}, {31'd0, wb_we});
			check({cur_name, ".rd"}, {27'd0, cur_rd}, {27'd0, wb_rd_adr});
			check({cur_name, ".data"}, cur_data, wb_data);
		end
	end

	initial begin
		logic [31:0] addrs [4];
		logic [`LSU_DMA_AW-1:0] dwa;
		logic [15:0] dwd;
		logic [15:0] held_new;
		{rst_n, stall, rst_pipe, cmd_ld, cmd_st, wbk_rd_reg, dma_we, dma_re} = 8'd0;
		ldst_code = LDST_W;
		{addr, st_data, rd_adr, dma_wadr, dma_radr, dma_wdata} = '0;
		for (int i = 0; i < `LSU_IO_REGS; i++)
			io_model[i] = 16'd0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// random words, then ALU pass-through
		for (int i = 0; i < 4; i++) begin
			addrs[i] = {18'd0, rand_bits(12), 2'b00};
			issue(0, 1, LDST_W, addrs[i], rand_bits(32), 5'd0, 0, "sw_rand");
		end
		for (int i = 0; i < 4; i++)
			issue(1, 0, LDST_W, addrs[i], 32'd0, 5'(i + 1), 1, "lw_rand");
		issue(0, 0, LDST_W, 32'h1234_5678, 32'd0, 5'd3, 1, "alu_pass");

		// byte and halfword merges
		issue(0, 1, LDST_W, 32'h100, 32'h1122_3344, 5'd0, 0, "sw_base");
		for (int o = 0; o < 4; o++) begin
			issue(0, 1, LDST_B, 32'h100 + o, rand_bits(8), 5'd0, 0, "sb");
			issue(1, 0, LDST_W, 32'h100, 32'd0, 5'd4, 1, "sb_merge");
			if (o % 2 == 0) begin
				issue(0, 1, LDST_H, 32'h100 + o, rand_bits(16), 5'd0, 0, "sh");
				issue(1, 0, LDST_W, 32'h100, 32'd0, 5'd5, 1, "sh_merge");
			end
		end

		// sub-word loads, mixed signs per lane
		issue(0, 1, LDST_W, 32'h104, 32'h8001_7ff0, 5'd0, 0, "sw_ext");
		for (int o = 0; o < 4; o++) begin
			issue(1, 0, LDST_B, 32'h104 + o, 32'd0, 5'd6, 1, "lb");
			issue(1, 0, LDST_BU, 32'h104 + o, 32'd0, 5'd7, 1, "lbu");
			if (o % 2 == 0) begin
				issue(1, 0, LDST_H, 32'h104 + o, 32'd0, 5'd8, 1, "lh");
				issue(1, 0, LDST_HU, 32'h104 + o, 32'd0, 5'd9, 1, "lhu");
			end
		end
		issue(1, 0, LDST_W, 32'h104, 32'd0, 5'd0, 1, "ld_x0");

		// IO region
		issue(0, 1, LDST_W, 32'h40, 32'h0000_1234, 5'd0, 0, "sw_ram40");
		issue(0, 1, LDST_W, 32'hc000_0040, 32'habcd_5a5a, 5'd0, 0, "sw_io");
		issue(1, 0, LDST_W, 32'hc000_0040, 32'd0, 5'd10, 1, "lw_io");
		issue(1, 0, LDST_W, 32'h40, 32'd0, 5'd11, 1, "lw_ram40");
		issue(0, 1, LDST_B, 32'hc000_0040, 32'h0000_00ff, 5'd0, 0, "sb_io");
		issue(1, 0, LDST_W, 32'hc000_0040, 32'd0, 5'd12, 1, "lw_io_sb");
		issue(0, 1, LDST_H, 32'hc000_0044, 32'h0000_8765, 5'd0, 0, "sh_io");
		issue(1, 0, LDST_W, 32'hc000_0044, 32'd0, 5'd13, 1, "lw_io_sh");

		// stall holds the load result, rst_pipe clears it
		issue(1, 0, LDST_W, 32'h100, 32'd0, 5'd14, 1, "stall_ld");
		@(posedge clk);
		stall <= 1'b1;
		@(posedge clk);
		// RAM word under the stalled load changes behind it
		held_new = ~ram_model[12'h040][15:0];
		ram_model[12'h040] = {16'd0, held_new};
		dma_we <= 1'b1;
		dma_wadr <= 14'h0040;
		dma_wdata <= held_new;
		@(posedge clk);
		dma_we <= 1'b0;
		repeat (2) @(posedge clk);
		rst_pipe <= 1'b1;
		issue(0, 0, LDST_W, 32'd0, 32'd0, 5'd0, 0, "flush_idle");
		rst_pipe <= 1'b0;
		stall <= 1'b0;

		// DMA write and read back, then CPU view of the same word
		issue(0, 0, LDST_W, 32'd0, 32'd0, 5'd0, 0, "dma_idle");
		dwa = {2'b00, rand_bits(12)};
		dwd = rand_bits(16) | 16'h0001;
		ram_model[dwa[`LSU_RAM_AW-1:0]] = {16'd0, dwd};
		@(posedge clk);
		dma_we <= 1'b1;
		dma_wadr <= dwa;
		dma_wdata <= dwd;
		@(posedge clk);
		dma_we <= 1'b0;
		dma_read_check(dwa, dwd);
		issue(1, 0, LDST_W, {18'd0, dwa[`LSU_RAM_AW-1:0], 2'b00}, 32'd0, 5'd15, 1, "lw_dma");

		repeat (2) @(posedge clk);
		$display("%0d errors", errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
